// ==== source/rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_index_t;
	typedef logic [3:0] tag_t;

	// major opcodes the decoder looks at.
	typedef enum logic [6:0] {
		opc_op = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui = 7'b0110111,
		opc_auipc = 7'b0010111,
		opc_jal = 7'b1101111,
		opc_jalr = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_store = 7'b0100011 // decoded only to raise a fault.
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [2:0] {
		sel_zero,
		sel_rs1,
		sel_rs2,
		sel_pc,
		sel_imm
	} operand_sel_t;

	// values match funct3 of the branch encodings.
	typedef enum logic [2:0] {
		cond_eq = 3'b000,
		cond_ne = 3'b001,
		cond_lt = 3'b100,
		cond_ge = 3'b101,
		cond_ltu = 3'b110,
		cond_geu = 3'b111
	} branch_cond_t;

	typedef struct packed {
		tag_t tag;
		logic epoch;
		word_t pc;
		word_t instruction;
	} fetch_data_t;

	typedef struct packed {
		tag_t tag;
		logic epoch;
		word_t pc;
		reg_index_t rs1;
		reg_index_t rs2;
		reg_index_t rd;
		word_t imm;
		alu_op_t alu_op;
		operand_sel_t operand1;
		operand_sel_t operand2;
		logic jump;
		logic jump_conditional;
		logic link_register_target;
		branch_cond_t branch_cond;
	} decode_data_t;

	typedef struct packed {
		word_t pc;
		reg_index_t rd;
		word_t result;
	} retire_t;

endpackage

// ==== source/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; #(
	parameter int IMEM_WORDS = 64
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_run,
	input logic i_imem_write,
	input word_t i_imem_address,
	input word_t i_imem_data,
	input logic i_busy,
	input logic i_fault,
	input logic i_redirect,
	input word_t i_redirect_pc,
	output fetch_data_t o_data
);

	localparam int ADDR_BITS = $clog2(IMEM_WORDS);

	word_t imem [IMEM_WORDS];
	word_t pc;
	logic epoch;
	logic running;
	logic issue;
	fetch_data_t data;

	assign o_data = data;

	// no item goes out in a redirect cycle.
	assign issue = (running || i_run) && !i_busy && !i_fault && !i_redirect;

	always_ff @(posedge i_clock) begin
		if (i_imem_write) begin
			imem[i_imem_address[ADDR_BITS+1:2]] <= i_imem_data; // byte address.
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= '0;
			epoch <= 1'b0;
			running <= 1'b0;
			data <= '0;
		end
		else begin
			if (i_run) begin
				running <= 1'b1;
			end
			if (i_redirect) begin
				pc <= i_redirect_pc;
				epoch <= ~epoch; // older items now stale.
			end
			else if (issue) begin
				data.tag <= data.tag + 1'b1;
				data.epoch <= epoch;
				data.pc <= pc;
				data.instruction <= imem[pc[ADDR_BITS+1:2]];
				pc <= pc + 32'd4;
			end
		end
	end

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input fetch_data_t i_data,
	input logic i_execute_busy,
	output logic o_busy,
	output decode_data_t o_data,
	output logic o_fault
);

	word_t instruction;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_r, is_i, is_s, is_b, is_u, is_j;
	logic have_rs1, have_rs2, have_rd;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	logic valid;
	logic accept;
	alu_op_t alu_op;
	operand_sel_t operand1;
	operand_sel_t operand2;
	decode_data_t data;

	function automatic alu_op_t funct_alu_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign instruction = i_data.instruction;
	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	assign is_r = opcode == opc_op;
	assign is_i = opcode == opc_op_imm || opcode == opc_jalr;
	assign is_s = opcode == opc_store;
	assign is_b = opcode == opc_branch;
	assign is_u = opcode == opc_lui || opcode == opc_auipc;
	assign is_j = opcode == opc_jal;

	assign have_rs1 = is_r | is_i | is_s | is_b;
	assign have_rs2 = is_r | is_s | is_b;
	assign have_rd = is_r | is_i | is_u | is_j;

	assign imm_i = {{21{instruction[31]}}, instruction[30:20]};
	assign imm_s = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
	assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign imm_u = {instruction[31:12], 12'b0};
	assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	always_comb begin
		valid = 1'b0;
		alu_op = alu_add;
		operand1 = sel_rs1;
		operand2 = sel_imm;
		case (opcode)
			opc_op: begin
				valid = funct7 == 7'b0 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				alu_op = funct_alu_op(funct3, funct7[5]);
				operand2 = sel_rs2;
			end
			opc_op_imm: begin
				valid = (funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0 ||
					(funct3 == 3'b101 && funct7 == 7'b0100000);
				alu_op = funct_alu_op(funct3, funct3 == 3'b101 && funct7[5]);
			end
			opc_lui: begin
				valid = 1'b1;
				alu_op = alu_pass_b;
				operand1 = sel_zero;
			end
			opc_auipc, opc_jal: begin
				valid = 1'b1;
				operand1 = sel_pc;
			end
			opc_jalr: begin
				valid = funct3 == 3'b000; // alu gives rs1 + imm.
			end
			opc_branch: begin
				valid = funct3[2:1] != 2'b01;
				operand1 = sel_pc; // alu gives the target.
			end
			default: begin
				valid = 1'b0;
			end
		endcase
	end

	assign accept = i_data.tag != data.tag && !i_execute_busy && !o_fault;

	assign o_busy = i_execute_busy;
	assign o_data = data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			data <= '0;
			o_fault <= 1'b0;
		end
		else if (accept) begin
			data.epoch <= i_data.epoch;
			data.pc <= i_data.pc;
			data.rs1 <= have_rs1 ? instruction[19:15] : 5'd0;
			data.rs2 <= have_rs2 ? instruction[24:20] : 5'd0;
			data.rd <= have_rd ? instruction[11:7] : 5'd0;
			data.imm <= is_b ? imm_b :
				is_i ? imm_i :
				is_j ? imm_j :
				is_s ? imm_s :
				is_u ? imm_u :
				32'd0;
			data.alu_op <= alu_op;
			data.operand1 <= operand1;
			data.operand2 <= operand2;
			data.jump <= is_j || opcode == opc_jalr;
			data.jump_conditional <= is_b;
			data.link_register_target <= opcode == opc_jalr;
			data.branch_cond <= is_b ? branch_cond_t'(funct3) : cond_eq;
			if (valid) begin
				data.tag <= i_data.tag;
			end
			else begin
				o_fault <= 1'b1; // item stops here.
			end
		end
	end

endmodule

// ==== source/rv_register_file.sv ====
`timescale 1ns/1ps

module rv_register_file import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input reg_index_t i_read_index_a,
	input reg_index_t i_read_index_b,
	input logic i_write_enable,
	input reg_index_t i_write_index,
	input word_t i_write_data,
	output word_t o_read_a,
	output word_t o_read_b
);

	word_t registers [32];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end
		else if (i_write_enable && i_write_index != 5'd0) begin
			registers[i_write_index] <= i_write_data; // x0 stays zero.
		end
	end

	assign o_read_a = registers[i_read_index_a];
	assign o_read_b = registers[i_read_index_b];

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input decode_data_t i_data,
	input logic i_hold,
	output logic o_busy,
	output logic o_redirect,
	output word_t o_redirect_pc,
	output logic o_retire_valid,
	output retire_t o_retire
);

	tag_t last_tag;
	logic epoch;
	logic accept;
	logic live;
	logic condition;
	logic taken;
	word_t rs1_value, rs2_value;
	word_t operand_a, operand_b;
	word_t alu_result;
	word_t target;
	word_t write_data;

	function automatic word_t select_operand(input operand_sel_t sel, input word_t rs1_v,
		input word_t rs2_v, input word_t pc, input word_t imm);
		case (sel)
			sel_rs1: return rs1_v;
			sel_rs2: return rs2_v;
			sel_pc: return pc;
			sel_imm: return imm;
			default: return '0;
		endcase
	endfunction

	rv_register_file u_register_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_read_index_a(i_data.rs1),
		.i_read_index_b(i_data.rs2),
		.i_write_enable(live),
		.i_write_index(i_data.rd),
		.i_write_data(write_data),
		.o_read_a(rs1_value),
		.o_read_b(rs2_value)
	);

	assign o_busy = i_hold;
	assign accept = i_data.tag != last_tag && !i_hold;
	assign live = accept && i_data.epoch == epoch; // stale items just consume the tag.

	assign operand_a = select_operand(i_data.operand1, rs1_value, rs2_value, i_data.pc,
		i_data.imm);
	assign operand_b = select_operand(i_data.operand2, rs1_value, rs2_value, i_data.pc,
		i_data.imm);

	always_comb begin
		case (i_data.alu_op)
			alu_add: alu_result = operand_a + operand_b;
			alu_sub: alu_result = operand_a - operand_b;
			alu_sll: alu_result = operand_a << operand_b[4:0];
			alu_slt: alu_result = {31'd0, $signed(operand_a) < $signed(operand_b)};
			alu_sltu: alu_result = {31'd0, operand_a < operand_b};
			alu_xor: alu_result = operand_a ^ operand_b;
			alu_srl: alu_result = operand_a >> operand_b[4:0];
			alu_sra: alu_result = $signed(operand_a) >>> operand_b[4:0];
			alu_or: alu_result = operand_a | operand_b;
			alu_and: alu_result = operand_a & operand_b;
			default: alu_result = operand_b;
		endcase
	end

	always_comb begin
		case (i_data.branch_cond)
			cond_eq: condition = rs1_value == rs2_value;
			cond_ne: condition = rs1_value != rs2_value;
			cond_lt: condition = $signed(rs1_value) < $signed(rs2_value);
			cond_ge: condition = $signed(rs1_value) >= $signed(rs2_value);
			cond_ltu: condition = rs1_value < rs2_value;
			default: condition = rs1_value >= rs2_value;
		endcase
	end

	assign taken = live && (i_data.jump || (i_data.jump_conditional && condition));
	assign target = i_data.link_register_target ? {alu_result[31:1], 1'b0} : alu_result;
	assign write_data = i_data.jump ? i_data.pc + 32'd4 : alu_result; // link value.

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			last_tag <= '0;
			epoch <= 1'b0;
			o_redirect <= 1'b0;
			o_retire_valid <= 1'b0;
		end
		else begin
			if (accept) begin
				last_tag <= i_data.tag;
			end
			epoch <= epoch ^ taken;
			o_redirect <= taken;
			o_retire_valid <= live;
		end
	end

	always_ff @(posedge i_clock) begin
		o_redirect_pc <= target;
		if (live) begin
			o_retire.pc <= i_data.pc;
			o_retire.rd <= i_data.rd;
			o_retire.result <= i_data.jump_conditional ? '0 : write_data; // branches report zero.
		end
	end

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
	parameter int IMEM_WORDS = 64
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_run,
	input logic i_hold,
	input logic i_imem_write,
	input word_t i_imem_address,
	input word_t i_imem_data,
	output logic o_retire_valid,
	output retire_t o_retire,
	output logic o_fault
);

	fetch_data_t fetch_data;
	decode_data_t decode_data;
	logic decode_busy;
	logic execute_busy;
	logic redirect;
	word_t redirect_pc;

	rv_fetch #(
		.IMEM_WORDS(IMEM_WORDS)
	) u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_run(i_run),
		.i_imem_write(i_imem_write),
		.i_imem_address(i_imem_address),
		.i_imem_data(i_imem_data),
		.i_busy(decode_busy),
		.i_fault(o_fault),
		.i_redirect(redirect),
		.i_redirect_pc(redirect_pc),
		.o_data(fetch_data)
	);

	rv_decode u_decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(fetch_data),
		.i_execute_busy(execute_busy),
		.o_busy(decode_busy),
		.o_data(decode_data),
		.o_fault(o_fault)
	);

	rv_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(decode_data),
		.i_hold(i_hold),
		.o_busy(execute_busy),
		.o_redirect(redirect),
		.o_redirect_pc(redirect_pc),
		.o_retire_valid(o_retire_valid),
		.o_retire(o_retire)
	);

endmodule

// ==== verification/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert import rv_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_hold,
	input logic i_retire_valid,
	input retire_t i_retire,
	input logic i_fault,
	input word_t i_x0_value
);

	int failures = 0;

	hold_blocks_retire: assert property (@(posedge i_clock) disable iff (i_reset)
		$past(i_hold) |-> !i_retire_valid)
		else begin
			failures++;
			$error("retire while the pipeline was held");
		end

	fault_is_sticky: assert property (@(posedge i_clock)
		$fell(i_fault) |-> $past(i_reset))
		else begin
			failures++;
			$error("fault cleared without reset");
		end

	no_retire_after_fault: assert property (@(posedge i_clock) disable iff (i_reset)
		$past(i_fault) |-> !i_retire_valid)
		else begin
			failures++;
			$error("retire after fault");
		end

	x0_stays_zero: assert property (@(posedge i_clock) disable iff (i_reset)
		i_retire_valid && i_retire.rd == 5'd0 |=> i_x0_value == '0)
		else begin
			failures++;
			$error("x0 changed after a retire to x0");
		end

endmodule

bind rv_core_top rv_core_assert u_assert (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_hold(i_hold),
	.i_retire_valid(o_retire_valid),
	.i_retire(o_retire),
	.i_fault(o_fault),
	.i_x0_value(u_execute.u_register_file.registers[0])
);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

	localparam logic [6:0] OPI = 7'b0010011;
	localparam logic [6:0] LUI = 7'b0110111;
	localparam logic [6:0] AUIPC = 7'b0010111;
	localparam logic [6:0] JALR = 7'b1100111;

	logic clock, reset, run, hold, imem_write, retire_valid, fault;
	word_t imem_address, imem_data;
	retire_t retire;
	int seed;
	word_t prog [64];
	int prog_len;
	retire_t expected [$];
	word_t model_regs [32];
	bit checking, hold_enable;
	string test_name;
	int test_errors, tests_passed, tests_failed, watchdog_cycles, total_words;

	rv_core_top #(.IMEM_WORDS(64)) dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_run(run),
		.i_hold(hold),
		.i_imem_write(imem_write),
		.i_imem_address(imem_address),
		.i_imem_data(imem_data),
		.o_retire_valid(retire_valid),
		.o_retire(retire),
		.o_fault(fault)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic word_t r_form(input logic [6:0] f7, input int rs2, input int rs1,
		input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic word_t i_form(input int imm, input int rs1, input logic [2:0] f3,
		input int rd, input logic [6:0] opc);
		return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic word_t u_form(input int imm20, input int rd, input logic [6:0] opc);
		return {20'(imm20), 5'(rd), opc};
	endfunction

	function automatic word_t j_form(input int off, input int rd);
		logic [20:0] o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
	endfunction

	function automatic word_t b_form(input int off, input int rs1, input int rs2,
		input logic [2:0] f3);
		logic [12:0] o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
	endfunction

	function automatic word_t alu_model(input logic [2:0] f3, input logic alt, input word_t a,
		input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) return $signed(a) >>> b[4:0]; // keeps the sign.
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic put(input word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic put_branch_pair(input logic [2:0] f3, input int nt1, input int nt2);
		put(b_form(8, nt1, nt2, f3)); // not taken.
		put(b_form(8, nt2, nt1, f3));
		put(i_form(9, 0, 0, 10, OPI)); // wrong path.
	endtask

	task automatic load_program(input int which);
		prog_len = 0;
		case (which)
			0: begin
				put(i_form(-1, 0, 0, 1, OPI));
				put(i_form(1, 0, 0, 2, OPI));
				put(i_form(31, 2, 3'd1, 2, OPI));
				put(i_form(100, 0, 0, 3, OPI));
				put(r_form(7'h00, 3, 1, 3'd0, 4));
				put(r_form(7'h20, 1, 3, 3'd0, 5));
				put(r_form(7'h00, 3, 3, 3'd1, 6));
				put(r_form(7'h00, 3, 2, 3'd5, 7));
				put(r_form(7'h20, 3, 2, 3'd5, 8));
				put(r_form(7'h00, 1, 2, 3'd2, 9));
				put(r_form(7'h00, 1, 2, 3'd3, 10));
				put(i_form(0, 1, 3'd2, 11, OPI));
				put(i_form(1, 1, 3'd3, 12, OPI));
				put(r_form(7'h00, 3, 1, 3'd4, 13));
				put(r_form(7'h00, 3, 2, 3'd6, 14));
				put(r_form(7'h00, 3, 1, 3'd7, 15));
				put(i_form(12'h405, 2, 3'd5, 16, OPI)); // srai.
				put(i_form(28, 1, 3'd5, 17, OPI));
				put(i_form(-1, 3, 3'd4, 18, OPI));
				put(i_form(255, 1, 3'd7, 19, OPI));
				put(i_form(-2048, 0, 3'd6, 20, OPI));
			end
			1: begin
				put(u_form(32'h12345, 1, LUI));
				put(u_form(32'hfffff, 2, AUIPC));
				put(i_form(-2048, 0, 0, 3, OPI));
				put(i_form(5, 1, 0, 0, OPI)); // x0 must stay zero.
				put(r_form(7'h00, 0, 0, 3'd0, 4));
				put(i_form(-1, 3, 0, 5, OPI));
			end
			2, 3: begin
				put(i_form(-5, 0, 0, 1, OPI));
				put(i_form(3, 0, 0, 2, OPI));
				put(b_form(8, 1, 2, 3'd0));
				put(i_form(1, 11, 0, 11, OPI));
				put(b_form(8, 0, 0, 3'd0));
				put(i_form(9, 0, 0, 10, OPI));
				put(b_form(8, 1, 1, 3'd1));
				put(b_form(8, 1, 2, 3'd1));
				put(i_form(9, 0, 0, 10, OPI));
				put_branch_pair(3'd4, 2, 1);
				put_branch_pair(3'd5, 1, 2);
				put_branch_pair(3'd6, 1, 2);
				put_branch_pair(3'd7, 2, 1);
				put(j_form(8, 5));
				put(i_form(9, 0, 0, 10, OPI));
				put(i_form(4 * 26 + 1, 0, 0, 6, OPI)); // odd target.
				put(i_form(0, 6, 0, 7, JALR));
				put(i_form(9, 0, 0, 10, OPI));
				put(i_form(0, 7, 0, 8, OPI));
			end
			default: begin
				put(i_form(7, 0, 0, 1, OPI));
				put(i_form(1, 1, 0, 2, OPI));
				put({7'd0, 5'd2, 5'd0, 3'b010, 5'd0, 7'b0100011}); // sw faults.
				put(i_form(3, 0, 0, 3, OPI));
			end
		endcase
		put(j_form(0, 0)); // park loop.
	endtask

	task automatic build_expected();
		word_t pc, ins, rs1v, rs2v, imm_i, res, next;
		reg_index_t rd;
		expected.delete();
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		pc = '0;
		for (int step = 0; step < 200; step++) begin
			ins = prog[pc[7:2]];
			if (ins == 32'h0000006f || ins[6:0] == 7'b0100011 || ins[6:0] == 7'b1110011)
				break;
			rs1v = model_regs[ins[19:15]];
			rs2v = model_regs[ins[24:20]];
			rd = ins[11:7];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			next = pc + 32'd4;
			res = '0;
			case (ins[6:0])
				7'b0110011: res = alu_model(ins[14:12], ins[30], rs1v, rs2v);
				7'b0010011: begin
					res = alu_model(ins[14:12], ins[14:12] == 3'd5 && ins[30], rs1v,
						imm_i);
				end
				7'b0110111: res = {ins[31:12], 12'd0};
				7'b0010111: res = pc + {ins[31:12], 12'd0};
				7'b1101111: begin
					res = pc + 32'd4;
					next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				7'b1100111: begin
					res = pc + 32'd4;
					next = (rs1v + imm_i) & ~32'd1;
				end
				default: begin
					rd = '0; // branches retire with no destination.
					if (branch_taken(ins[14:12], rs1v, rs2v))
						next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			endcase
			expected.push_back(retire_t'{pc: pc, rd: rd, result: res});
			if (rd != 0) model_regs[rd] = res;
			pc = next;
		end
	endtask

	always @(negedge clock) begin
		hold <= hold_enable && ($random(seed) & 1);
	end

	always @(posedge clock) begin
		if (checking && retire_valid && expected.size() > 0) begin
			assert (retire == expected[0]) else begin
				$display("ERROR %s: expected pc=%h rd=%0d result=%h, actual pc=%h rd=%0d result=%h",
					test_name, expected[0].pc, expected[0].rd, expected[0].result,
					retire.pc, retire.rd, retire.result);
				test_errors++;
			end
			void'(expected.pop_front());
		end
	end

	task automatic run_test(input string name, input int which, input bit with_hold,
		input bit expect_fault);
		test_name = name;
		test_errors = 0;
		load_program(which);
		build_expected();
		@(negedge clock);
		reset = 1'b1;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < 64; i++) begin
			imem_write = 1'b1;
			imem_address = i * 4;
			imem_data = i < prog_len ? prog[i] : i_form(i, 0, 0, 0, OPI); // nop fill.
			@(negedge clock);
		end
		imem_write = 1'b0;
		checking = 1'b1;
		hold_enable <= with_hold;
		run = 1'b1;
		@(negedge clock);
		run = 1'b0;
		wait (expected.size() == 0);
		if (expect_fault) wait (fault);
		repeat (20) @(posedge clock);
		@(negedge clock);
		hold_enable <= 1'b0;
		checking = 1'b0;
		assert (fault == expect_fault) else begin
			$display("ERROR %s: expected fault=%0d, actual fault=%0d", name, expect_fault, fault);
			test_errors++;
		end
		if (test_errors == 0) tests_passed++;
		else tests_failed++;
		$display("test %s finished with %0d errors", name, test_errors);
	endtask

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		seed = 89795;
		reset = 1'b1;
		run = 1'b0;
		hold = 1'b0;
		imem_write = 1'b0;
		imem_address = '0;
		imem_data = '0;
		checking = 1'b0;
		hold_enable = 1'b0;
		tests_passed = 0;
		tests_failed = 0;
		total_words = 0;
		for (int w = 0; w < 5; w++) begin
			load_program(w);
			total_words += prog_len;
		end
		watchdog_cycles = 200 * total_words;
		run_test("arithmetic", 0, 1'b0, 1'b0);
		run_test("upper_immediate", 1, 1'b0, 1'b0);
		run_test("branches_jumps", 2, 1'b0, 1'b0);
		run_test("random_hold", 3, 1'b1, 1'b0);
		run_test("unsupported_fault", 4, 1'b0, 1'b1);
		$display("tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, dut.u_assert.failures);
		if (tests_failed == 0 && dut.u_assert.failures == 0) begin
			$display("RESULT: PASS");
		end
		else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_register_file.sv
source/rv_execute.sv
source/rv_core_top.sv
verification/rv_core_assert.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_fetch.sv
  - source/rv_decode.sv
  - source/rv_register_file.sv
  - source/rv_execute.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - verification/rv_core_assert.sv
      - verification/rv_core_tb.sv
